/* source/profiler_config.svh */
// Widths and sizes for the core profiler.
// Included by the package and by any block that needs raw sizes.

`ifndef PROFILER_CONFIG_SVH
`define PROFILER_CONFIG_SVH

`define PROF_DATA_W       32  // load address width
`define PROF_REG_ADDR_W   5
`define PROF_NUM_REGS     32  // scoreboard depth
`define PROF_DMEM_ADDR_W  10  // local dmem word address
`define PROF_CTR_W        32

// address bits marking where a remote load goes
`define PROF_DRAM_BIT     31
`define PROF_GLOBAL_BIT   30
`define PROF_GROUP_BIT    29

`endif

/* source/profiler_pkg.sv */
// Types shared by the core profiler blocks.
// Counter indices, increment vector and the packed input bundles.
`default_nettype none

`include "profiler_config.svh"

package profiler_pkg;

  typedef logic [`PROF_DATA_W-1:0]     addr_t;
  typedef logic [`PROF_REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [`PROF_CTR_W-1:0]      ctr_t;

  typedef enum logic [4:0] {
    STAT_CYCLE, STAT_INSTR,
    STAT_LOCAL_LD, STAT_LOCAL_ST, STAT_REMOTE_LD, STAT_REMOTE_ST,
    STAT_ICACHE_MISS,
    STAT_BRANCH, STAT_BRANCH_MISS, STAT_JALR, STAT_JALR_MISS, STAT_JAL,
    STAT_STALL_DEPEND, STAT_DEPEND_LOCAL, STAT_DEPEND_REMOTE,
    STAT_DEPEND_DRAM, STAT_DEPEND_GLOBAL, STAT_DEPEND_GROUP,
    STAT_STALL_IFETCH, STAT_STALL_REMOTE_REQ, STAT_STALL_MD, STAT_STALL_FORCE_WB
  } stat_id_e;

  // one increment flag per counter
  typedef logic [STAT_STALL_FORCE_WB:0] stat_inc_t;

  // pending load origin per register
  typedef struct packed {
    logic from_dram;
    logic from_global;
    logic from_group;
    logic from_local;
  } load_origin_t;

  typedef struct packed {
    logic has_instr;
    logic icache_miss;
    logic is_branch;
    logic is_jalr;
    logic is_jal;
    logic writes_rf;
    logic reads_rf2;
  } exe_info_t;

  typedef struct packed {
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     reads_rf1;
    logic     reads_rf2;
  } id_info_t;

  typedef struct packed {
    logic stall;
    logic stall_depend;
    logic ifetch_wait;
    logic remote_req;
    logic md;
    logic force_wb;
  } stall_info_t;

  typedef struct packed {
    logic v;
    logic yumi;
    logic write_not_read;
    logic icache_fetch;
  } remote_req_t;

  typedef struct packed {
    logic     local_v;
    reg_idx_t local_id;
    logic     remote_v;
    reg_idx_t remote_id;
  } sb_clear_t;

endpackage

`default_nettype wire

/* source/event_classifier.sv */
// Per-cycle instruction, memory and plain stall events.
// Purely combinational; feeds the counter bank alongside the dependency tracker.
`timescale 1ns/1ns
`default_nettype none

module event_classifier (
  input  wire profiler_pkg::exe_info_t   exe_i,
  input  wire profiler_pkg::stall_info_t stall_i,
  input  wire profiler_pkg::remote_req_t remote_req_i,
  input  wire                            branch_mispredict_i,
  input  wire                            jalr_mispredict_i,
  input  wire                            dmem_v_i,
  input  wire                            dmem_w_i,
  output profiler_pkg::stat_inc_t        events_o
);

  import profiler_pkg::*;

  logic instr_inc;
  logic dmem_xfer;
  logic net_xfer;
  logic branch_inc;
  logic jalr_inc;
  logic other_stall;

  // retired this cycle
  assign instr_inc = exe_i.has_instr & ~exe_i.icache_miss & ~stall_i.stall;

  assign dmem_xfer = dmem_v_i & ~stall_i.stall;
  assign net_xfer  = remote_req_i.v & remote_req_i.yumi; // request accepted by network

  assign branch_inc = instr_inc & exe_i.is_branch;
  assign jalr_inc   = instr_inc & exe_i.is_jalr;

  // a forced writeback only counts when nothing else explains the stall
  assign other_stall = stall_i.ifetch_wait | stall_i.remote_req | stall_i.md;

  always_comb begin
    events_o = '0;

    events_o[STAT_INSTR] = instr_inc;

    events_o[STAT_LOCAL_LD] = dmem_xfer & ~dmem_w_i & exe_i.writes_rf;
    events_o[STAT_LOCAL_ST] = dmem_xfer & dmem_w_i & exe_i.reads_rf2;

    events_o[STAT_REMOTE_LD] = net_xfer & ~remote_req_i.write_not_read
                               & ~remote_req_i.icache_fetch & exe_i.writes_rf;
    events_o[STAT_REMOTE_ST] = net_xfer & remote_req_i.write_not_read
                               & exe_i.reads_rf2;
    events_o[STAT_ICACHE_MISS] = net_xfer & ~remote_req_i.write_not_read
                                 & remote_req_i.icache_fetch;

    events_o[STAT_BRANCH]      = branch_inc;
    events_o[STAT_BRANCH_MISS] = branch_inc & branch_mispredict_i;
    events_o[STAT_JALR]        = jalr_inc;
    events_o[STAT_JALR_MISS]   = jalr_inc & jalr_mispredict_i;
    events_o[STAT_JAL]         = instr_inc & exe_i.is_jal;

    events_o[STAT_STALL_IFETCH]     = stall_i.ifetch_wait;
    events_o[STAT_STALL_REMOTE_REQ] = stall_i.remote_req;
    events_o[STAT_STALL_MD]         = stall_i.md;
    events_o[STAT_STALL_FORCE_WB]   = stall_i.force_wb & ~other_stall;
  end

endmodule

`default_nettype wire

/* source/dependency_tracker.sv */
// Tracks where each register's pending load comes from and charges
// dependency stalls to that origin. Scoreboard updates land at the edge.
`timescale 1ns/1ns
`default_nettype none

`include "profiler_config.svh"

module dependency_tracker (
  input  wire                            clk_i,
  input  wire                            reset_i,
  input  wire profiler_pkg::id_info_t    id_i,
  input  wire profiler_pkg::stall_info_t stall_i,
  input  wire                            sb_score_i,
  input  wire profiler_pkg::addr_t       load_addr_i,
  input  wire profiler_pkg::sb_clear_t   sb_clear_i,
  output profiler_pkg::stat_inc_t        events_o
);

  import profiler_pkg::*;

  localparam int local_bit_lp = 2 + `PROF_DMEM_ADDR_W; // word index plus byte offset

  load_origin_t                        origin;
  load_origin_t [`PROF_NUM_REGS-1:0]   sb_r;
  load_origin_t                        rs1_origin;
  load_origin_t                        rs2_origin;
  load_origin_t                        waiting;
  logic                                is_local;
  logic                                depend_inc;

  // classify the load address
  assign is_local = load_addr_i[local_bit_lp]
                    & (load_addr_i[`PROF_DATA_W-1:local_bit_lp+1] == '0);

  always_comb begin
    origin = '0;
    if (is_local) begin
      origin.from_local = 1'b1;
    end else if (load_addr_i[`PROF_DRAM_BIT]) begin
      origin.from_dram = 1'b1;
    end else if (load_addr_i[`PROF_GLOBAL_BIT]) begin
      origin.from_global = 1'b1;
    end else if (load_addr_i[`PROF_GROUP_BIT]) begin
      origin.from_group = 1'b1;
    end
  end

  // clears first, so a set to the same bit takes priority
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sb_r <= '0;
    end else begin
      if (sb_clear_i.local_v) begin
        sb_r[sb_clear_i.local_id].from_local <= 1'b0;
      end
      if (sb_clear_i.remote_v) begin
        sb_r[sb_clear_i.remote_id].from_dram   <= 1'b0;
        sb_r[sb_clear_i.remote_id].from_global <= 1'b0;
        sb_r[sb_clear_i.remote_id].from_group  <= 1'b0;
      end
      if (sb_score_i & origin.from_local) begin
        sb_r[id_i.rd].from_local <= 1'b1;
      end
      if (sb_score_i & origin.from_dram) begin
        sb_r[id_i.rd].from_dram <= 1'b1;
      end
      if (sb_score_i & origin.from_global) begin
        sb_r[id_i.rd].from_global <= 1'b1;
      end
      if (sb_score_i & origin.from_group) begin
        sb_r[id_i.rd].from_group <= 1'b1;
      end
    end
  end

  // origins of the sources the stalled instruction actually reads
  assign rs1_origin = id_i.reads_rf1 ? sb_r[id_i.rs1] : '0;
  assign rs2_origin = id_i.reads_rf2 ? sb_r[id_i.rs2] : '0;
  assign waiting    = rs1_origin | rs2_origin;

  assign depend_inc = stall_i.stall_depend & ~stall_i.stall;

  always_comb begin
    events_o = '0;
    events_o[STAT_STALL_DEPEND]  = depend_inc;
    events_o[STAT_DEPEND_LOCAL]  = depend_inc & waiting.from_local;
    events_o[STAT_DEPEND_DRAM]   = depend_inc & waiting.from_dram;
    events_o[STAT_DEPEND_GLOBAL] = depend_inc & waiting.from_global;
    events_o[STAT_DEPEND_GROUP]  = depend_inc & waiting.from_group;
    events_o[STAT_DEPEND_REMOTE] = depend_inc
                                   & (waiting.from_dram | waiting.from_global
                                      | waiting.from_group);
  end

endmodule

`default_nettype wire

/* source/stat_counter_bank.sv */
// Event counters with a combinational read port.
// Each flagged counter goes up by one per edge; the cycle counter always does.
`timescale 1ns/1ns
`default_nettype none

module stat_counter_bank (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire profiler_pkg::stat_inc_t instr_events_i,
  input  wire profiler_pkg::stat_inc_t depend_events_i,
  input  wire profiler_pkg::stat_id_e  stat_sel_i,
  output profiler_pkg::ctr_t           stat_value_o
);

  import profiler_pkg::*;

  localparam int num_stats_lp = $bits(stat_inc_t);

  stat_inc_t                   inc;
  ctr_t [num_stats_lp-1:0]     ctr_r;

  always_comb begin
    inc = instr_events_i | depend_events_i;
    inc[STAT_CYCLE] = 1'b1; // ticks whenever out of reset
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctr_r <= '0;
    end else begin
      for (int i = 0; i < num_stats_lp; i++) begin
        if (inc[i]) begin
          ctr_r[i] <= ctr_r[i] + 1'b1; // wraps
        end
      end
    end
  end

  // indices past the last counter read as zero
  assign stat_value_o = (int'(stat_sel_i) < num_stats_lp) ? ctr_r[stat_sel_i] : '0;

endmodule

`default_nettype wire

/* source/core_profiler.sv */
// Top of the per-core profiler.
// Classifier and dependency tracker feed one counter bank; read any counter by index.
`timescale 1ns/1ns
`default_nettype none

module core_profiler (
  input  wire                            clk_i,
  input  wire                            reset_i,
  input  wire profiler_pkg::exe_info_t   exe_i,
  input  wire profiler_pkg::id_info_t    id_i,
  input  wire profiler_pkg::stall_info_t stall_i,
  input  wire profiler_pkg::remote_req_t remote_req_i,
  input  wire                            branch_mispredict_i,
  input  wire                            jalr_mispredict_i,
  input  wire                            dmem_v_i,
  input  wire                            dmem_w_i,
  input  wire                            sb_score_i,
  input  wire profiler_pkg::addr_t       load_addr_i,
  input  wire profiler_pkg::sb_clear_t   sb_clear_i,
  input  wire profiler_pkg::stat_id_e    stat_sel_i,
  output profiler_pkg::ctr_t             stat_value_o
);

  import profiler_pkg::*;

  stat_inc_t instr_events;
  stat_inc_t depend_events;

  event_classifier i_event_classifier (
    .exe_i               (exe_i),
    .stall_i             (stall_i),
    .remote_req_i        (remote_req_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .dmem_v_i            (dmem_v_i),
    .dmem_w_i            (dmem_w_i),
    .events_o            (instr_events)
  );

  dependency_tracker i_dependency_tracker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .id_i        (id_i),
    .stall_i     (stall_i),
    .sb_score_i  (sb_score_i),
    .load_addr_i (load_addr_i),
    .sb_clear_i  (sb_clear_i),
    .events_o    (depend_events)
  );

  stat_counter_bank i_stat_counter_bank (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .instr_events_i  (instr_events),
    .depend_events_i (depend_events),
    .stat_sel_i      (stat_sel_i),
    .stat_value_o    (stat_value_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_core_profiler.sv */
// Testbench for the core profiler.
// Replays cycle records from the stimulus file and reads counters back by index.
`timescale 1ns/1ns
`default_nettype none

module tb_core_profiler;

  import profiler_pkg::*;

  localparam int num_records_lp = 43; // C, E and T lines in the stimulus file
  localparam int cycle_limit_lp = 2 * num_records_lp + 20;

  logic        clk_i;
  logic        reset_i;
  exe_info_t   exe_i;
  id_info_t    id_i;
  stall_info_t stall_i;
  remote_req_t remote_req_i;
  logic        branch_mispredict_i;
  logic        jalr_mispredict_i;
  logic        dmem_v_i;
  logic        dmem_w_i;
  logic        sb_score_i;
  addr_t       load_addr_i;
  sb_clear_t   sb_clear_i;
  stat_id_e    stat_sel_i;
  ctr_t        stat_value_o;

  int fd;
  int code;
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int records = 0;
  int test_checks = 0;
  int test_errors = 0;
  int f_test;
  logic [7:0]       kind;
  logic [8*128-1:0] line;
  logic [6:0]       f_exe;
  logic [5:0]       f_stall;
  logic [3:0]       f_rreq;
  logic [4:0]       f_misc; // bmis jmis dmem_v dmem_w score
  logic [4:0]       f_rd, f_rs1, f_rs2, f_lid, f_rid, f_id;
  logic [1:0]       f_rdf;
  logic             f_lv, f_rv;
  addr_t            f_addr;
  ctr_t             f_exp;

  core_profiler i_core_profiler (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit_lp) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic drive_idle;
    exe_i <= '0;
    id_i <= '0;
    stall_i <= '0;
    remote_req_i <= '0;
    {branch_mispredict_i, jalr_mispredict_i, dmem_v_i, dmem_w_i, sb_score_i} <= '0;
    load_addr_i <= '0;
    sb_clear_i <= '0;
  endtask

  task automatic check_stat(input stat_id_e id, input ctr_t expected);
    assert (stat_value_o == expected) else begin
      $display("ERR %0t: %s expected %0d, read %0d", $time, id.name(), expected, stat_value_o);
      errors++;
      test_errors++;
    end
    test_checks++;
  endtask

  task automatic check_fields(input int got, input int wanted);
    if (got != wanted) begin
      $display("record %0d has %0d of %0d fields in the stimulus file", records, got, wanted);
      errors++;
    end
  endtask

  initial begin
    reset_i = 1'b1;
    exe_i = '0;
    id_i = '0;
    stall_i = '0;
    remote_req_i = '0;
    {branch_mispredict_i, jalr_mispredict_i, dmem_v_i, dmem_w_i, sb_score_i} = '0;
    load_addr_i = '0;
    sb_clear_i = '0;
    stat_sel_i = STAT_CYCLE;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    fd = $fopen("testbench/profiler_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": code = $fgets(line, fd);
          "C": begin
            records++;
            code = $fscanf(fd, "%b %b %b %b %d %d %d %b %h %b %d %b %d",
                           f_exe, f_stall, f_rreq, f_misc, f_rd, f_rs1, f_rs2, f_rdf,
                           f_addr, f_lv, f_lid, f_rv, f_rid);
            check_fields(code, 13);
            @(posedge clk_i);
            exe_i <= f_exe;
            stall_i <= f_stall;
            remote_req_i <= f_rreq;
            {branch_mispredict_i, jalr_mispredict_i, dmem_v_i, dmem_w_i, sb_score_i} <= f_misc;
            id_i <= {f_rd, f_rs1, f_rs2, f_rdf};
            load_addr_i <= f_addr;
            sb_clear_i <= {f_lv, f_lid, f_rv, f_rid};
          end
          "E": begin
            records++;
            code = $fscanf(fd, "%d %d", f_id, f_exp);
            check_fields(code, 2);
            @(posedge clk_i);
            drive_idle();
            stat_sel_i <= stat_id_e'(f_id);
            @(negedge clk_i); // read port settled
            check_stat(stat_id_e'(f_id), f_exp);
          end
          "T": begin
            records++;
            code = $fscanf(fd, "%d", f_test);
            check_fields(code, 1);
            $display("test %0d: %0d checks, %0d failed", f_test, test_checks, test_errors);
            checks += test_checks;
            tests++;
            test_checks = 0;
            test_errors = 0;
          end
          default: begin
            $display("unknown record type in the stimulus file");
            errors++;
          end
        endcase
      end
      $fclose(fd);
      if (records != num_records_lp) begin
        $display("stimulus file held %0d records instead of %0d", records, num_records_lp);
        errors++;
      end
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* core_profiler.f */
+incdir+source
source/profiler_pkg.sv
source/event_classifier.sv
source/dependency_tracker.sv
source/stat_counter_bank.sv
source/core_profiler.sv
testbench/tb_core_profiler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the profiler testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --assert --timescale 1ns/1ns --top-module tb_core_profiler \
  -f core_profiler.f -o tb_sim &&
./obj_dir/tb_sim | tee sim.log &&
grep -qx "No errors" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* testbench/profiler_stimulus.txt */
# C exe[7b] stall[6b] rreq[4b] misc[bmis jmis dmem_v dmem_w score] rd rs1 rs2 rdf addr lv lid rv rid
# E stat_id expected ; T test_no closes a test ; bit fields MSB first as in the packed structs
E 1 0
E 0 2
T 1
C 1000000 000000 0000 00000 0 0 0 00 00000000 0 0 0 0
C 1100000 000000 0000 00000 0 0 0 00 00000000 0 0 0 0
C 1000000 100000 0000 00000 0 0 0 00 00000000 0 0 0 0
C 1010000 000000 0000 10000 0 0 0 00 00000000 0 0 0 0
C 1001000 000000 0000 00000 0 0 0 00 00000000 0 0 0 0
C 1000100 000000 0000 01000 0 0 0 00 00000000 0 0 0 0
E 1 4
E 8 1
E 10 0
T 2
C 0000010 000000 0000 00100 0 0 0 00 00000000 0 0 0 0
C 0000001 100000 0000 00110 0 0 0 00 00000000 0 0 0 0
C 0000001 000000 1110 00000 0 0 0 00 00000000 0 0 0 0
C 0000000 000000 1101 00000 0 0 0 00 00000000 0 0 0 0
C 0000010 000000 1000 00000 0 0 0 00 00000000 0 0 0 0
E 2 1
E 3 0
E 4 0
E 5 1
E 6 1
T 3
C 0000000 000000 0000 00001 5 0 0 00 80000000 0 0 0 0
C 0000000 010000 0000 00000 0 5 0 10 00000000 0 0 0 0
C 0000000 000000 0000 00000 0 0 0 00 00000000 0 0 1 5
C 0000000 010000 0000 00000 0 5 0 10 00000000 0 0 0 0
E 12 2
E 14 1
E 15 1
T 4
C 0000000 000000 0000 00001 7 0 0 00 00001000 1 7 0 0
C 0000000 010000 0000 00000 0 0 7 01 00000000 0 0 0 0
E 13 1
T 5
C 0000000 110000 0000 00000 0 0 7 01 00000000 0 0 0 0
C 0000000 000011 0000 00000 0 0 0 00 00000000 0 0 0 0
C 0000000 000001 0000 00000 0 0 0 00 00000000 0 0 0 0
E 12 3
E 21 1
E 0 37
T 6
